//--- design/cmac_ctl_params.svh
/*
 * sizes for the 100G MAC control and statistics block
 * statistic input widths follow the MAC hard core ports and must not be changed alone
 */
`ifndef CMAC_CTL_PARAMS_SVH
`define CMAC_CTL_PARAMS_SVH

`define CMAC_STAT_CNT_W       32 // packet and byte accumulators
`define CMAC_ERR_CNT_W        16 // error event counters

`define CMAC_AXIL_ADDR_W      8
`define CMAC_AXIL_DATA_W      32

// per-cycle increments from the core
`define CMAC_RX_TOTAL_BYTES_W 7
`define CMAC_RX_GOOD_BYTES_W  14
`define CMAC_RX_TOTAL_PKTS_W  3
`define CMAC_TX_TOTAL_BYTES_W 6
`define CMAC_TX_GOOD_BYTES_W  14
`define CMAC_ERR_CODE_W       3

`endif

//--- design/cmac_ctl_pkg.sv
/*
 * types shared by the MAC control blocks and the register port
 * counter structs are laid out in register map order
 */
`include "cmac_ctl_params.svh"

package cmac_ctl_pkg;

    // bring-up sequence, same encoding for rx and tx
    typedef enum logic [3:0] {
        LINK_IDLE         = 4'd0,
        LINK_GT_LOCKED    = 4'd1,
        LINK_WAIT_ALIGNED = 4'd2,
        LINK_PKT_TRANSFER = 4'd3
    } link_state_e;

    // byte addresses of the read-only registers
    typedef enum logic [`CMAC_AXIL_ADDR_W-1:0] {
        REG_STATUS         = 8'h00,
        REG_RX_GOOD_PKTS   = 8'h04,
        REG_RX_TOTAL_PKTS  = 8'h08,
        REG_RX_GOOD_BYTES  = 8'h0C,
        REG_RX_TOTAL_BYTES = 8'h10,
        REG_TX_GOOD_PKTS   = 8'h14,
        REG_TX_TOTAL_PKTS  = 8'h18,
        REG_TX_GOOD_BYTES  = 8'h1C,
        REG_TX_TOTAL_BYTES = 8'h20,
        REG_ERR_ALIGN      = 8'h24,
        REG_ERR_CODE       = 8'h28,
        REG_ERR_FCS        = 8'h2C,
        REG_ERR_PREAMBLE   = 8'h30,
        REG_ERR_SFD        = 8'h34,
        REG_TX_OVF         = 8'h38,
        REG_TX_UNF         = 8'h3C
    } reg_addr_e;

    typedef struct packed {
        logic                              rx_good_pkts;
        logic [`CMAC_RX_TOTAL_PKTS_W-1:0]  rx_total_pkts;
        logic [`CMAC_RX_GOOD_BYTES_W-1:0]  rx_good_bytes;
        logic [`CMAC_RX_TOTAL_BYTES_W-1:0] rx_total_bytes;
        logic                              tx_good_pkts;
        logic                              tx_total_pkts;
        logic [`CMAC_TX_GOOD_BYTES_W-1:0]  tx_good_bytes;
        logic [`CMAC_TX_TOTAL_BYTES_W-1:0] tx_total_bytes;
    } cmac_stat_t;

    typedef struct packed {
        logic                        aligned_err;
        logic [`CMAC_ERR_CODE_W-1:0] bad_code;
        logic [`CMAC_ERR_CODE_W-1:0] bad_fcs;
        logic                        bad_preamble;
        logic                        bad_sfd;
        logic                        tx_ovf;
        logic                        tx_unf;
    } cmac_err_t;

    typedef struct packed {
        logic rx_enable;
        logic tx_enable;
        logic tx_send_lfi;
        logic tx_send_rfi;
    } link_ctl_t;

    typedef struct packed {
        logic [`CMAC_STAT_CNT_W-1:0] rx_good_pkts;
        logic [`CMAC_STAT_CNT_W-1:0] rx_total_pkts;
        logic [`CMAC_STAT_CNT_W-1:0] rx_good_bytes;
        logic [`CMAC_STAT_CNT_W-1:0] rx_total_bytes;
        logic [`CMAC_STAT_CNT_W-1:0] tx_good_pkts;
        logic [`CMAC_STAT_CNT_W-1:0] tx_total_pkts;
        logic [`CMAC_STAT_CNT_W-1:0] tx_good_bytes;
        logic [`CMAC_STAT_CNT_W-1:0] tx_total_bytes;
    } stat_cnt_t;

    typedef struct packed {
        logic [`CMAC_ERR_CNT_W-1:0] align;
        logic [`CMAC_ERR_CNT_W-1:0] code;
        logic [`CMAC_ERR_CNT_W-1:0] fcs;
        logic [`CMAC_ERR_CNT_W-1:0] preamble;
        logic [`CMAC_ERR_CNT_W-1:0] sfd;
        logic [`CMAC_ERR_CNT_W-1:0] tx_ovf;
        logic [`CMAC_ERR_CNT_W-1:0] tx_unf;
    } err_cnt_t;

    typedef struct packed {
        logic [`CMAC_AXIL_ADDR_W-1:0] araddr;
        logic                         arvalid;
    } axil_ar_t;

    typedef struct packed {
        logic [`CMAC_AXIL_DATA_W-1:0] rdata;
        logic [1:0]                   rresp;
        logic                         rvalid;
    } axil_r_t;

endpackage

//--- design/rx_link_fsm.sv
/*
 * receive bring-up for the MAC core
 * stat_rx_aligned must already be synchronous to gt_txusrclk2
 */
`timescale 1ns/10ps

module rx_link_fsm import cmac_ctl_pkg::*; (
    input  logic        gt_txusrclk2,
    input  logic        usr_rx_reset_w,
    input  logic        stat_rx_aligned,
    output logic        aligned_q,
    output logic        rx_enable,
    output link_state_e rx_state
);

    logic reset_done; // one cycle of settling after reset

    always_ff @(posedge gt_txusrclk2) begin
        if (usr_rx_reset_w) begin
            rx_state   <= LINK_IDLE;
            rx_enable  <= 1'b0;
            aligned_q  <= 1'b0;
            reset_done <= 1'b0;
        end else begin
            reset_done <= 1'b1;
            aligned_q  <= stat_rx_aligned;
            case (rx_state)
                LINK_IDLE: begin
                    rx_enable <= 1'b0; // drop enable before relocking
                    if (reset_done) begin
                        rx_state <= LINK_GT_LOCKED;
                    end
                end
                LINK_GT_LOCKED: begin
                    rx_enable <= 1'b1;
                    rx_state  <= LINK_WAIT_ALIGNED;
                end
                LINK_WAIT_ALIGNED: begin
                    if (aligned_q) begin
                        rx_state <= LINK_PKT_TRANSFER;
                    end
                end
                LINK_PKT_TRANSFER: begin
                    // alignment lost so restart the sequence
                    if (!aligned_q) begin
                        rx_state <= LINK_IDLE;
                    end
                end
                default: rx_state <= LINK_IDLE;
            endcase
        end
    end

endmodule

//--- design/tx_link_fsm.sv
/*
 * transmit bring-up for the MAC core
 * sends local and remote fault until the receive side reports alignment
 */
`timescale 1ns/10ps

module tx_link_fsm import cmac_ctl_pkg::*; (
    input  logic        gt_txusrclk2,
    input  logic        usr_rx_reset_w,
    input  logic        aligned_q,
    output logic        tx_enable,
    output logic        tx_send_lfi,
    output logic        tx_send_rfi,
    output link_state_e tx_state
);

    logic reset_done;

    always_ff @(posedge gt_txusrclk2) begin
        if (usr_rx_reset_w) begin
            tx_state    <= LINK_IDLE;
            tx_enable   <= 1'b0;
            tx_send_lfi <= 1'b0;
            tx_send_rfi <= 1'b0;
            reset_done  <= 1'b0;
        end else begin
            reset_done <= 1'b1;
            case (tx_state)
                LINK_IDLE: begin
                    tx_enable   <= 1'b0;
                    tx_send_lfi <= 1'b0;
                    tx_send_rfi <= 1'b0;
                    if (reset_done) begin
                        tx_state <= LINK_GT_LOCKED;
                    end
                end
                LINK_GT_LOCKED: begin
                    // tell the far end we are not ready yet
                    tx_enable   <= 1'b0;
                    tx_send_lfi <= 1'b1;
                    tx_send_rfi <= 1'b1;
                    tx_state    <= LINK_WAIT_ALIGNED;
                end
                LINK_WAIT_ALIGNED: begin
                    if (aligned_q) begin
                        tx_state <= LINK_PKT_TRANSFER;
                    end
                end
                LINK_PKT_TRANSFER: begin
                    tx_enable   <= 1'b1;
                    tx_send_lfi <= 1'b0; // faults off together with enable
                    tx_send_rfi <= 1'b0;
                    if (!aligned_q) begin
                        tx_state <= LINK_IDLE;
                    end
                end
                default: tx_state <= LINK_IDLE;
            endcase
        end
    end

endmodule

//--- design/stat_accumulator.sv
/*
 * running sums of the per-cycle packet and byte statistics
 * accumulators wrap silently and clear only on reset
 */
`timescale 1ns/10ps
`include "cmac_ctl_params.svh"

module stat_accumulator import cmac_ctl_pkg::*; (
    input  logic       gt_txusrclk2,
    input  logic       usr_rx_reset_w,
    input  cmac_stat_t cmac_stat,
    output stat_cnt_t  stat_cnt
);

    stat_cnt_t inc; // increments widened to counter size

    always_comb begin
        inc.rx_good_pkts   = `CMAC_STAT_CNT_W'(cmac_stat.rx_good_pkts);
        inc.rx_total_pkts  = `CMAC_STAT_CNT_W'(cmac_stat.rx_total_pkts);
        inc.rx_good_bytes  = `CMAC_STAT_CNT_W'(cmac_stat.rx_good_bytes);
        inc.rx_total_bytes = `CMAC_STAT_CNT_W'(cmac_stat.rx_total_bytes);
        inc.tx_good_pkts   = `CMAC_STAT_CNT_W'(cmac_stat.tx_good_pkts);
        inc.tx_total_pkts  = `CMAC_STAT_CNT_W'(cmac_stat.tx_total_pkts);
        inc.tx_good_bytes  = `CMAC_STAT_CNT_W'(cmac_stat.tx_good_bytes);
        inc.tx_total_bytes = `CMAC_STAT_CNT_W'(cmac_stat.tx_total_bytes);
    end

    always_ff @(posedge gt_txusrclk2) begin
        if (usr_rx_reset_w) begin
            stat_cnt <= '0;
        end else begin
            // rx side
            stat_cnt.rx_good_pkts   <= stat_cnt.rx_good_pkts + inc.rx_good_pkts;
            stat_cnt.rx_total_pkts  <= stat_cnt.rx_total_pkts + inc.rx_total_pkts;
            stat_cnt.rx_good_bytes  <= stat_cnt.rx_good_bytes + inc.rx_good_bytes;
            stat_cnt.rx_total_bytes <= stat_cnt.rx_total_bytes + inc.rx_total_bytes;
            // tx side
            stat_cnt.tx_good_pkts   <= stat_cnt.tx_good_pkts + inc.tx_good_pkts;
            stat_cnt.tx_total_pkts  <= stat_cnt.tx_total_pkts + inc.tx_total_pkts;
            stat_cnt.tx_good_bytes  <= stat_cnt.tx_good_bytes + inc.tx_good_bytes;
            stat_cnt.tx_total_bytes <= stat_cnt.tx_total_bytes + inc.tx_total_bytes;
        end
    end

endmodule

//--- design/error_counter.sv
/*
 * counts cycles with receive errors and tx FIFO faults
 * a multi-bit flag counts once per cycle however many lanes report it
 */
`timescale 1ns/10ps
`include "cmac_ctl_params.svh"

module error_counter import cmac_ctl_pkg::*; (
    input  logic      gt_txusrclk2,
    input  logic      usr_rx_reset_w,
    input  cmac_err_t cmac_err,
    output err_cnt_t  err_cnt
);

    localparam logic [`CMAC_ERR_CNT_W-1:0] ONE = `CMAC_ERR_CNT_W'(1);

    always_ff @(posedge gt_txusrclk2) begin
        if (usr_rx_reset_w) begin
            err_cnt <= '0;
        end else begin
            if (cmac_err.aligned_err) begin
                err_cnt.align <= err_cnt.align + ONE;
            end
            if (|cmac_err.bad_code) begin
                err_cnt.code <= err_cnt.code + ONE;
            end
            if (|cmac_err.bad_fcs) begin
                err_cnt.fcs <= err_cnt.fcs + ONE;
            end
            if (cmac_err.bad_preamble) begin
                err_cnt.preamble <= err_cnt.preamble + ONE;
            end
            if (cmac_err.bad_sfd) begin
                err_cnt.sfd <= err_cnt.sfd + ONE;
            end
            if (cmac_err.tx_ovf) begin // tx FIFO overflow
                err_cnt.tx_ovf <= err_cnt.tx_ovf + ONE;
            end
            if (cmac_err.tx_unf) begin
                err_cnt.tx_unf <= err_cnt.tx_unf + ONE;
            end
        end
    end

endmodule

//--- design/stat_axil_regs.sv
/*
 * AXI4-Lite read-only view of link state and all counters
 * one read in flight at a time and no write channels
 * unmapped or unaligned addresses return SLVERR with zero data
 */
`timescale 1ns/10ps
`include "cmac_ctl_params.svh"

module stat_axil_regs import cmac_ctl_pkg::*; (
    input  logic        gt_txusrclk2,
    input  logic        usr_rx_reset_w,
    input  axil_ar_t    axil_ar,
    output logic        axil_arready,
    output axil_r_t     axil_r,
    input  logic        axil_rready,
    input  link_ctl_t   link_ctl,
    input  logic        aligned_q,
    input  link_state_e rx_state,
    input  link_state_e tx_state,
    input  stat_cnt_t   stat_cnt,
    input  err_cnt_t    err_cnt
);

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    logic [`CMAC_AXIL_DATA_W-1:0] rd_data;
    logic [`CMAC_AXIL_DATA_W-1:0] rdata_q;
    logic [1:0]                   rd_resp;
    logic [1:0]                   rresp_q;
    logic                         rvalid_q;
    logic [15:0]                  status;
    logic                         ar_fire;

    assign ar_fire = axil_ar.arvalid & axil_arready;

    // rx_enable lands in bit 0
    assign status = {tx_state, rx_state, 3'b000, aligned_q, link_ctl.tx_send_rfi,
                     link_ctl.tx_send_lfi, link_ctl.tx_enable, link_ctl.rx_enable};

    always_comb begin
        rd_data = '0;
        rd_resp = RESP_OKAY;
        case (reg_addr_e'(axil_ar.araddr))
            REG_STATUS:         rd_data = `CMAC_AXIL_DATA_W'(status);
            REG_RX_GOOD_PKTS:   rd_data = `CMAC_AXIL_DATA_W'(stat_cnt.rx_good_pkts);
            REG_RX_TOTAL_PKTS:  rd_data = `CMAC_AXIL_DATA_W'(stat_cnt.rx_total_pkts);
            REG_RX_GOOD_BYTES:  rd_data = `CMAC_AXIL_DATA_W'(stat_cnt.rx_good_bytes);
            REG_RX_TOTAL_BYTES: rd_data = `CMAC_AXIL_DATA_W'(stat_cnt.rx_total_bytes);
            REG_TX_GOOD_PKTS:   rd_data = `CMAC_AXIL_DATA_W'(stat_cnt.tx_good_pkts);
            REG_TX_TOTAL_PKTS:  rd_data = `CMAC_AXIL_DATA_W'(stat_cnt.tx_total_pkts);
            REG_TX_GOOD_BYTES:  rd_data = `CMAC_AXIL_DATA_W'(stat_cnt.tx_good_bytes);
            REG_TX_TOTAL_BYTES: rd_data = `CMAC_AXIL_DATA_W'(stat_cnt.tx_total_bytes);
            REG_ERR_ALIGN:      rd_data = `CMAC_AXIL_DATA_W'(err_cnt.align);
            REG_ERR_CODE:       rd_data = `CMAC_AXIL_DATA_W'(err_cnt.code);
            REG_ERR_FCS:        rd_data = `CMAC_AXIL_DATA_W'(err_cnt.fcs);
            REG_ERR_PREAMBLE:   rd_data = `CMAC_AXIL_DATA_W'(err_cnt.preamble);
            REG_ERR_SFD:        rd_data = `CMAC_AXIL_DATA_W'(err_cnt.sfd);
            REG_TX_OVF:         rd_data = `CMAC_AXIL_DATA_W'(err_cnt.tx_ovf);
            REG_TX_UNF:         rd_data = `CMAC_AXIL_DATA_W'(err_cnt.tx_unf);
            default:            rd_resp = RESP_SLVERR;
        endcase
    end

    // handshake, arready is the inverse of rvalid once out of reset
    always_ff @(posedge gt_txusrclk2) begin
        if (usr_rx_reset_w) begin
            rvalid_q     <= 1'b0;
            axil_arready <= 1'b0;
        end else if (ar_fire) begin
            rvalid_q     <= 1'b1;
            axil_arready <= 1'b0;
        end else if (rvalid_q && axil_rready) begin
            rvalid_q     <= 1'b0;
            axil_arready <= 1'b1;
        end else begin
            axil_arready <= ~rvalid_q; // stays low under back-pressure
        end
    end

    // data and response captured at the accepting edge
    always_ff @(posedge gt_txusrclk2) begin
        if (ar_fire) begin
            rdata_q <= rd_data;
            rresp_q <= rd_resp;
        end
    end

    assign axil_r = '{rdata: rdata_q, rresp: rresp_q, rvalid: rvalid_q};

endmodule

//--- design/cmac_ctl_top.sv
/*
 * control and monitoring around the 100G MAC hard core
 * the core itself is outside, status comes in and control bits go out
 * everything runs on gt_txusrclk2 with one synchronous reset
 */
`timescale 1ns/10ps

module cmac_ctl_top import cmac_ctl_pkg::*; (
    input  logic       gt_txusrclk2,
    input  logic       usr_rx_reset_w,
    input  logic       stat_rx_aligned,
    input  cmac_stat_t cmac_stat,
    input  cmac_err_t  cmac_err,
    output link_ctl_t  link_ctl,
    input  axil_ar_t   axil_ar,
    output logic       axil_arready,
    output axil_r_t    axil_r,
    input  logic       axil_rready
);

    logic        aligned_q;
    logic        rx_enable;
    logic        tx_enable;
    logic        tx_send_lfi;
    logic        tx_send_rfi;
    link_state_e rx_state;
    link_state_e tx_state;
    stat_cnt_t   stat_cnt;
    err_cnt_t    err_cnt;

    rx_link_fsm u_rx_link_fsm (
        .gt_txusrclk2    (gt_txusrclk2),
        .usr_rx_reset_w  (usr_rx_reset_w),
        .stat_rx_aligned (stat_rx_aligned),
        .aligned_q       (aligned_q),
        .rx_enable       (rx_enable),
        .rx_state        (rx_state)
    );

    tx_link_fsm u_tx_link_fsm (
        .gt_txusrclk2   (gt_txusrclk2),
        .usr_rx_reset_w (usr_rx_reset_w),
        .aligned_q      (aligned_q), // registered copy from the rx side
        .tx_enable      (tx_enable),
        .tx_send_lfi    (tx_send_lfi),
        .tx_send_rfi    (tx_send_rfi),
        .tx_state       (tx_state)
    );

    assign link_ctl = '{rx_enable: rx_enable, tx_enable: tx_enable,
                        tx_send_lfi: tx_send_lfi, tx_send_rfi: tx_send_rfi};

    stat_accumulator u_stat_accumulator (
        .gt_txusrclk2   (gt_txusrclk2),
        .usr_rx_reset_w (usr_rx_reset_w),
        .cmac_stat      (cmac_stat),
        .stat_cnt       (stat_cnt)
    );

    error_counter u_error_counter (
        .gt_txusrclk2   (gt_txusrclk2),
        .usr_rx_reset_w (usr_rx_reset_w),
        .cmac_err       (cmac_err),
        .err_cnt        (err_cnt)
    );

    stat_axil_regs u_stat_axil_regs (
        .gt_txusrclk2   (gt_txusrclk2),
        .usr_rx_reset_w (usr_rx_reset_w),
        .axil_ar        (axil_ar),
        .axil_arready   (axil_arready),
        .axil_r         (axil_r),
        .axil_rready    (axil_rready),
        .link_ctl       (link_ctl),
        .aligned_q      (aligned_q),
        .rx_state       (rx_state),
        .tx_state       (tx_state),
        .stat_cnt       (stat_cnt),
        .err_cnt        (err_cnt)
    );

endmodule

//--- test/cmac_ctl_asserts.sv
/*
 * protocol checks bound into the register port
 * sees the AXI read channel and the link control bits of the top level
 */
`timescale 1ns/10ps

module cmac_ctl_asserts import cmac_ctl_pkg::*; (
    input logic      gt_txusrclk2,
    input logic      usr_rx_reset_w,
    input logic      axil_arready,
    input axil_r_t   axil_r,
    input logic      axil_rready,
    input link_ctl_t link_ctl
);

    // response held until the master takes it
    rvalid_held: assert property (@(posedge gt_txusrclk2) disable iff (usr_rx_reset_w)
        axil_r.rvalid && !axil_rready |=> axil_r.rvalid && $stable(axil_r.rdata))
        else $error("rvalid or rdata changed before rready");

    one_in_flight: assert property (@(posedge gt_txusrclk2) disable iff (usr_rx_reset_w)
        !(axil_arready && axil_r.rvalid))
        else $error("arready and rvalid high together");

    no_fault_while_sending: assert property (@(posedge gt_txusrclk2)
        disable iff (usr_rx_reset_w)
        !(link_ctl.tx_enable && link_ctl.tx_send_lfi))
        else $error("tx_enable high while local fault is sent");

endmodule

bind stat_axil_regs cmac_ctl_asserts u_cmac_ctl_asserts (
    .gt_txusrclk2   (gt_txusrclk2),
    .usr_rx_reset_w (usr_rx_reset_w),
    .axil_arready   (axil_arready),
    .axil_r         (axil_r),
    .axil_rready    (axil_rready),
    .link_ctl       (link_ctl)
);

//--- test/cmac_ctl_tb.sv
/*
 * testbench for the MAC control block driven from a step table
 * inputs change and outputs are checked on the falling edge
 */
`timescale 1ns/10ps
`include "cmac_ctl_params.svh"

module cmac_ctl_tb import cmac_ctl_pkg::*; ();

    localparam int CLK_PERIOD  = 40;
    localparam int STEP_BUDGET = 80;  // cycles per step covering the 64 cycle stats run
    localparam logic [1:0] OKAY   = 2'b00;
    localparam logic [1:0] SLVERR = 2'b10;

    typedef enum logic [2:0] {
        STEP_ALIGN, STEP_STATS, STEP_ERRS, STEP_READ, STEP_RESET
    } step_kind_e;

    typedef struct {
        step_kind_e  kind;
        logic [7:0]  addr;
        int          count;     // cycles or rready stall for reads
        logic [31:0] value;     // expected data, level or error pattern
        logic        use_model;
        logic [1:0]  resp;
    } step_t;

    logic gt_txusrclk2 = 1'b0;
    logic usr_rx_reset_w;
    logic stat_rx_aligned;
    cmac_stat_t cmac_stat;
    cmac_err_t  cmac_err;
    link_ctl_t  link_ctl;
    axil_ar_t   axil_ar;
    logic       axil_arready;
    axil_r_t    axil_r;
    logic       axil_rready;
    logic [3:0] ctl_vec;  // rx_enable, tx_enable, lfi, rfi from msb down

    step_t steps[$];
    logic  table_ready = 1'b0;
    int    errors = 0;
    int unsigned seed_draw;

    // reference sums in register map order
    logic [`CMAC_STAT_CNT_W-1:0] stat_sum [8];
    logic [`CMAC_ERR_CNT_W-1:0]  err_sum [7];

    always #(CLK_PERIOD / 2) gt_txusrclk2 = ~gt_txusrclk2;

    assign ctl_vec = link_ctl;

    cmac_ctl_top UUT (.*);

    task automatic abort_run(string msg);
        errors++;
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at first failing check");
    endtask

    task automatic report_mismatch(string what, logic [31:0] got, logic [31:0] exp);
        abort_run($sformatf("ERR %0t ns: %s got %h expected %h", $time, what, got, exp));
    endtask

    function automatic void add_step(step_kind_e kind, logic [7:0] addr, int count,
                                     logic [31:0] value, logic use_model, logic [1:0] resp);
        step_t s;
        s.kind      = kind;
        s.addr      = addr;
        s.count     = count;
        s.value     = value;
        s.use_model = use_model;
        s.resp      = resp;
        steps.push_back(s);
    endfunction

    // status layout with rx_enable in bit 0
    function automatic logic [31:0] status_word(logic rx_en, logic tx_en, logic lfi, logic rfi,
                                                logic aligned, link_state_e rx_st,
                                                link_state_e tx_st);
        return {16'd0, tx_st, rx_st, 3'd0, aligned, rfi, lfi, tx_en, rx_en};
    endfunction

    function automatic logic [31:0] model_value(logic [7:0] addr);
        int idx;
        idx = int'(addr[7:2]);
        if (idx >= 1 && idx <= 8) return 32'(stat_sum[idx - 1]);
        if (idx >= 9 && idx <= 15) return 32'(err_sum[idx - 9]);
        return 32'd0;
    endfunction

    task automatic wait_for_ctl(logic [3:0] mask, logic [3:0] want, int limit, string what);
        int n;
        for (n = 0; n < limit && (ctl_vec & mask) != want; n++) begin
            @(negedge gt_txusrclk2);
        end
        assert ((ctl_vec & mask) == want)
            else abort_run($sformatf("%s did not happen within %0d cycles", what, limit));
    endtask

    task automatic apply_reset();
        int edge_n;
        usr_rx_reset_w  = 1'b1;
        stat_rx_aligned = 1'b0;
        cmac_stat       = '0;
        cmac_err        = '0;
        axil_ar         = '0;
        axil_rready     = 1'b1;
        repeat (4) begin
            @(negedge gt_txusrclk2);
            assert (ctl_vec == 4'b0000) else report_mismatch("link_ctl in reset", 32'(ctl_vec), 0);
            assert (!axil_arready && !axil_r.rvalid)
                else abort_run("read channel active during reset");
        end
        usr_rx_reset_w = 1'b0;
        foreach (stat_sum[k]) stat_sum[k] = '0;
        foreach (err_sum[k]) err_sum[k] = '0;
        // rx_enable and both fault bits rise on the third edge
        for (edge_n = 1; edge_n <= 3; edge_n++) begin
            @(negedge gt_txusrclk2);
            assert (ctl_vec == ((edge_n == 3) ? 4'b1011 : 4'b0000))
                else report_mismatch("link_ctl after release", 32'(ctl_vec),
                                     (edge_n == 3) ? 32'hB : 32'h0);
        end
        assert (axil_arready && !axil_r.rvalid) else abort_run("arready not up after reset");
    endtask

    task automatic set_alignment(logic level);
        int n;
        stat_rx_aligned = level;
        if (level) begin
            for (n = 1; n <= 3; n++) begin
                @(negedge gt_txusrclk2);
                assert (ctl_vec == ((n == 3) ? 4'b1100 : 4'b1011))
                    else report_mismatch("link_ctl after alignment", 32'(ctl_vec),
                                         (n == 3) ? 32'hC : 32'hB);
            end
        end else begin
            wait_for_ctl(4'b0100, 4'b0000, 4, "tx_enable drop");
            wait_for_ctl(4'b1000, 4'b0000, 4, "rx_enable drop");
            wait_for_ctl(4'b0011, 4'b0011, 4, "fault bits return");
            wait_for_ctl(4'b1000, 4'b1000, 4, "rx_enable recovery");
        end
    endtask

    task automatic drive_stats(int cycles);
        logic [63:0] rnd;
        repeat (cycles) begin
            rnd = {$urandom, $urandom};
            cmac_stat = rnd[$bits(cmac_stat_t)-1:0];
            stat_sum[0] = stat_sum[0] + `CMAC_STAT_CNT_W'(cmac_stat.rx_good_pkts);
            stat_sum[1] = stat_sum[1] + `CMAC_STAT_CNT_W'(cmac_stat.rx_total_pkts);
            stat_sum[2] = stat_sum[2] + `CMAC_STAT_CNT_W'(cmac_stat.rx_good_bytes);
            stat_sum[3] = stat_sum[3] + `CMAC_STAT_CNT_W'(cmac_stat.rx_total_bytes);
            stat_sum[4] = stat_sum[4] + `CMAC_STAT_CNT_W'(cmac_stat.tx_good_pkts);
            stat_sum[5] = stat_sum[5] + `CMAC_STAT_CNT_W'(cmac_stat.tx_total_pkts);
            stat_sum[6] = stat_sum[6] + `CMAC_STAT_CNT_W'(cmac_stat.tx_good_bytes);
            stat_sum[7] = stat_sum[7] + `CMAC_STAT_CNT_W'(cmac_stat.tx_total_bytes);
            @(negedge gt_txusrclk2);
        end
        cmac_stat = '0;
    endtask

    // fixed pattern when nonzero and random when zero
    task automatic drive_errors(int cycles, logic [31:0] pattern);
        logic [31:0] rnd;
        repeat (cycles) begin
            rnd = $urandom;
            cmac_err = (pattern != 0) ? pattern[$bits(cmac_err_t)-1:0]
                                      : rnd[$bits(cmac_err_t)-1:0];
            if (cmac_err.aligned_err) err_sum[0] = err_sum[0] + `CMAC_ERR_CNT_W'(1);
            if (|cmac_err.bad_code) err_sum[1] = err_sum[1] + `CMAC_ERR_CNT_W'(1);
            if (|cmac_err.bad_fcs) err_sum[2] = err_sum[2] + `CMAC_ERR_CNT_W'(1);
            if (cmac_err.bad_preamble) err_sum[3] = err_sum[3] + `CMAC_ERR_CNT_W'(1);
            if (cmac_err.bad_sfd) err_sum[4] = err_sum[4] + `CMAC_ERR_CNT_W'(1);
            if (cmac_err.tx_ovf) err_sum[5] = err_sum[5] + `CMAC_ERR_CNT_W'(1);
            if (cmac_err.tx_unf) err_sum[6] = err_sum[6] + `CMAC_ERR_CNT_W'(1);
            @(negedge gt_txusrclk2);
        end
        cmac_err = '0;
    endtask

    task automatic read_register(logic [7:0] addr, int stall, logic [31:0] value,
                                 logic use_model, logic [1:0] resp);
        int n;
        logic [31:0] exp;
        logic [31:0] held_data;
        logic [1:0]  held_resp;
        axil_ar     = '{araddr: addr, arvalid: 1'b1};
        axil_rready = (stall == 0);
        for (n = 0; n < 8 && !axil_r.rvalid; n++) begin
            @(negedge gt_txusrclk2);
        end
        assert (axil_r.rvalid) else abort_run("no read response within 8 cycles");
        exp = use_model ? model_value(addr) : value;
        assert (axil_r.rresp == resp)
            else report_mismatch($sformatf("rresp at %h", addr), 32'(axil_r.rresp), 32'(resp));
        assert (axil_r.rdata == exp)
            else report_mismatch($sformatf("rdata at %h", addr), axil_r.rdata, exp);
        assert (!axil_arready) else abort_run("arready high while a response is pending");
        held_data       = axil_r.rdata;
        held_resp       = axil_r.rresp;
        axil_ar.araddr  = 8'hFC;  // a second request must not be taken
        repeat (stall) begin
            @(negedge gt_txusrclk2);
            assert (axil_r.rvalid && !axil_arready)
                else abort_run("read channel moved under back-pressure");
            assert (axil_r.rdata == held_data && axil_r.rresp == held_resp)
                else report_mismatch("rdata under back-pressure", axil_r.rdata, held_data);
        end
        axil_ar     = '0;
        axil_rready = 1'b1;
        for (n = 0; n < 4 && axil_r.rvalid; n++) begin
            @(negedge gt_txusrclk2);
        end
        assert (!axil_r.rvalid) else abort_run("rvalid still high after rready");
    endtask

    initial begin
        seed_draw       = $urandom(72);
        usr_rx_reset_w  = 1'b1;
        stat_rx_aligned = 1'b0;
        cmac_stat       = '0;
        cmac_err        = '0;
        axil_ar         = '0;
        axil_rready     = 1'b1;

        add_step(STEP_RESET, 0, 0, 0, 0, OKAY);
        add_step(STEP_ALIGN, 0, 0, 1, 0, OKAY);
        add_step(STEP_READ, REG_STATUS, 0,
                 status_word(1, 1, 0, 0, 1, LINK_PKT_TRANSFER, LINK_PKT_TRANSFER), 0, OKAY);
        add_step(STEP_STATS, 0, 64, 0, 0, OKAY);
        for (int a = 4; a <= 32; a += 4) begin
            add_step(STEP_READ, 8'(a), (a == 12) ? 5 : 0, 0, 1, OKAY);
        end
        add_step(STEP_ERRS, 0, 3, 32'h6BB, 0, OKAY);  // multi-bit code and fcs with most flags
        add_step(STEP_ERRS, 0, 2, 32'h240, 0, OKAY);  // code and fcs upper lanes only
        add_step(STEP_ERRS, 0, 40, 0, 0, OKAY);
        for (int a = 36; a <= 60; a += 4) begin
            add_step(STEP_READ, 8'(a), 0, 0, 1, OKAY);
        end
        add_step(STEP_READ, 8'h40, 0, 0, 0, SLVERR);
        add_step(STEP_READ, 8'h06, 4, 0, 0, SLVERR);
        add_step(STEP_ALIGN, 0, 0, 0, 0, OKAY);
        add_step(STEP_READ, REG_STATUS, 3,
                 status_word(1, 0, 1, 1, 0, LINK_WAIT_ALIGNED, LINK_WAIT_ALIGNED), 0, OKAY);
        add_step(STEP_STATS, 0, 16, 0, 0, OKAY);
        add_step(STEP_ERRS, 0, 8, 0, 0, OKAY);
        add_step(STEP_RESET, 0, 0, 0, 0, OKAY);
        for (int a = 4; a <= 60; a += 4) begin
            add_step(STEP_READ, 8'(a), 0, 0, 1, OKAY);
        end
        add_step(STEP_READ, REG_STATUS, 0,
                 status_word(1, 0, 1, 1, 0, LINK_WAIT_ALIGNED, LINK_WAIT_ALIGNED), 0, OKAY);
        table_ready = 1'b1;

        foreach (steps[i]) begin
            case (steps[i].kind)
                STEP_RESET: apply_reset();
                STEP_ALIGN: set_alignment(steps[i].value[0]);
                STEP_STATS: drive_stats(steps[i].count);
                STEP_ERRS:  drive_errors(steps[i].count, steps[i].value);
                default:    read_register(steps[i].addr, steps[i].count, steps[i].value,
                                          steps[i].use_model, steps[i].resp);
            endcase
        end

        if (errors == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            $display("TEST RESULT: FAIL");
            $fatal(1, "checks failed");
        end
    end

    // watchdog sized from the table length
    initial begin
        wait (table_ready);
        #(CLK_PERIOD * STEP_BUDGET * steps.size() + 20 * CLK_PERIOD);
        $display("run timed out at %0t ns before all steps finished", $time);
        $display("TEST RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- vlog.f
+incdir+design
design/cmac_ctl_pkg.sv
design/rx_link_fsm.sv
design/tx_link_fsm.sv
design/stat_accumulator.sv
design/error_counter.sv
design/stat_axil_regs.sv
design/cmac_ctl_top.sv
test/cmac_ctl_asserts.sv
test/cmac_ctl_tb.sv

//--- run_sim.sh
#!/bin/sh
# builds the testbench with Verilator, runs it and greps the output for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/10ps -f vlog.f \
    --top-module cmac_ctl_tb || exit 1
out=$(./obj_dir/Vcmac_ctl_tb 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "TEST RESULT: PASS" && exit 0 || exit 1
